//--- cache_pkg.sv
// Memory system shared definitions
package cache_pkg;

   // Word and address geometry
   localparam int word_w = 16;
   localparam int index_w = 8;
   localparam int tag_w = 5;
   localparam int word_sel_w = 2;

   // Cache organisation
   localparam int num_lines = 256;
   localparam int line_words = 4;

   // Interleaved main memory
   localparam int num_banks = 4;
   localparam int row_w = 13;
   localparam int bank_lat = 2;

   // Controller states
   localparam int state_w = 3;
   localparam logic [state_w-1:0] st_idle = 3'd0;
   localparam logic [state_w-1:0] st_comp = 3'd1;
   localparam logic [state_w-1:0] st_wb = 3'd2;
   localparam logic [state_w-1:0] st_fill = 3'd3;
   localparam logic [state_w-1:0] st_done = 3'd4;
   localparam logic [state_w-1:0] st_err = 3'd5;

   // One address word seen by the cache and by the banks
   // Word select and bank number share bits 2:1
   typedef union packed {
      struct packed {
         logic [index_w-1:0] index;
         logic [tag_w-1:0] tag;
         logic [word_sel_w-1:0] word_sel;
         logic byte_sel;
      } cache;
      struct packed {
         logic [row_w-1:0] row;
         logic [word_sel_w-1:0] bank;
         logic byte_sel;
      } bank;
   } addr_u;

endpackage

//--- cache_array.sv
// Direct-mapped cache storage
`timescale 1ns/10ps

module cache_array (
   input  logic clk,
   input  logic rst,
   input  logic en,
   input  logic cmp,
   input  logic write,
   input  logic valid_in,
   input  logic dirty_in,
   input  logic [cache_pkg::index_w-1:0] index,
   input  logic [cache_pkg::tag_w-1:0] tag,
   input  logic [cache_pkg::word_sel_w-1:0] word_sel,
   input  logic [cache_pkg::word_w-1:0] wdata,
   output logic hit,
   output logic valid,
   output logic dirty,
   output logic [cache_pkg::tag_w-1:0] tag_out,
   output logic [cache_pkg::word_w-1:0] rdata
);

   // Per-line state bits
   logic [cache_pkg::num_lines-1:0] valid_bits;
   logic [cache_pkg::num_lines-1:0] dirty_bits;

   // Tag and data arrays
   logic [cache_pkg::tag_w-1:0] tag_mem [cache_pkg::num_lines];
   logic [cache_pkg::word_w-1:0] data_mem [cache_pkg::num_lines][cache_pkg::line_words];

   // Line state update
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (en && write) begin
         if (cmp) begin
            // Processor write marks the line modified
            dirty_bits[index] <= 1'b1;
         end else begin
            // Fill word from memory
            valid_bits[index] <= valid_in;
            dirty_bits[index] <= dirty_in;
         end
      end
   end

   // Tag and data writes
   always_ff @(posedge clk) begin
      if (en && write) begin
         data_mem[index][word_sel] <= wdata;
         if (!cmp) begin
            tag_mem[index] <= tag;
         end
      end
   end

   // Lookup is combinational
   assign valid = valid_bits[index];
   assign dirty = dirty_bits[index];
   assign tag_out = tag_mem[index];
   assign rdata = data_mem[index][word_sel];
   assign hit = valid && (tag_out == tag);

   // Controller only writes processor data into a resident line
   a_cmp_write_hit : assert property (
      @(posedge clk) disable iff (rst) (en && write && cmp) |-> hit
   );

endmodule

//--- cache_ctrl.sv
// Cache controller FSM
`timescale 1ns/10ps

module cache_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic [cache_pkg::word_w-1:0] addr,
   input  logic [cache_pkg::word_w-1:0] wdata,
   input  logic rd,
   input  logic wr,
   output logic [cache_pkg::word_w-1:0] rdata,
   output logic done,
   output logic cache_hit,
   output logic stall,
   output logic err,
   output logic arr_en,
   output logic arr_cmp,
   output logic arr_write,
   output logic arr_valid_in,
   output logic arr_dirty_in,
   output logic [cache_pkg::index_w-1:0] arr_index,
   output logic [cache_pkg::tag_w-1:0] arr_tag,
   output logic [cache_pkg::word_sel_w-1:0] arr_word_sel,
   output logic [cache_pkg::word_w-1:0] arr_wdata,
   input  logic arr_hit,
   input  logic arr_valid,
   input  logic arr_dirty,
   input  logic [cache_pkg::tag_w-1:0] arr_tag_out,
   input  logic [cache_pkg::word_w-1:0] arr_rdata,
   output logic mem_rd,
   output logic mem_wr,
   output logic [cache_pkg::word_w-1:0] mem_addr,
   output logic [cache_pkg::word_w-1:0] mem_wdata,
   input  logic mem_busy,
   input  logic mem_rvalid,
   input  logic [cache_pkg::word_sel_w-1:0] mem_rword,
   input  logic [cache_pkg::word_w-1:0] mem_rdata
);

   logic [cache_pkg::state_w-1:0] state;
   logic [cache_pkg::state_w-1:0] state_nx;
   // Issued words with bit 2 set once all four fill reads are sent
   logic [2:0] cnt;
   // Returned fill words
   logic [1:0] ret_cnt;
   logic mem_take;

   // Latched request
   cache_pkg::addr_u req_a;
   cache_pkg::addr_u mem_a;
   logic [cache_pkg::word_w-1:0] req_wdata;
   logic req_wr;
   logic [cache_pkg::word_w-1:0] rdata_q;

   assign mem_take = (mem_rd || mem_wr) && !mem_busy;

   // Next state
   always_comb begin
      state_nx = state;
      case (state)
         cache_pkg::st_idle: begin
            if (rd && wr) begin
               state_nx = cache_pkg::st_err;
            end else if (rd || wr) begin
               state_nx = cache_pkg::st_comp;
            end
         end
         cache_pkg::st_comp: begin
            if (arr_hit) begin
               state_nx = cache_pkg::st_idle;
            end else if (arr_valid && arr_dirty) begin
               state_nx = cache_pkg::st_wb;
            end else begin
               state_nx = cache_pkg::st_fill;
            end
         end
         cache_pkg::st_wb: begin
            // Last evicted word accepted
            if (mem_take && cnt[1:0] == 2'd3) begin
               state_nx = cache_pkg::st_fill;
            end
         end
         cache_pkg::st_fill: begin
            if (mem_rvalid && ret_cnt == 2'd3) begin
               state_nx = cache_pkg::st_done;
            end
         end
         cache_pkg::st_done: state_nx = cache_pkg::st_idle;
         default: state_nx = cache_pkg::st_err;
      endcase
   end

   // State and counters
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= cache_pkg::st_idle;
         cnt <= '0;
         ret_cnt <= '0;
      end else begin
         state <= state_nx;
         // Issue count restarts on every state change
         if (state_nx != state) begin
            cnt <= '0;
         end else if (mem_take) begin
            cnt <= cnt + 3'd1;
         end
         if (state == cache_pkg::st_fill && mem_rvalid) begin
            ret_cnt <= ret_cnt + 2'd1;
         end
      end
   end

   // Request capture and miss read word
   always_ff @(posedge clk) begin
      if (state == cache_pkg::st_idle && (rd || wr)) begin
         req_a <= addr;
         req_wdata <= wdata;
         req_wr <= wr;
      end
      if (state == cache_pkg::st_fill && mem_rvalid && mem_rword == req_a.cache.word_sel) begin
         rdata_q <= mem_rdata;
      end
   end

   // Cache array control
   always_comb begin
      arr_en = 1'b0;
      arr_cmp = 1'b0;
      arr_write = 1'b0;
      arr_valid_in = 1'b0;
      arr_dirty_in = 1'b0;
      arr_index = req_a.cache.index;
      arr_tag = req_a.cache.tag;
      arr_word_sel = req_a.cache.word_sel;
      arr_wdata = req_wdata;
      case (state)
         cache_pkg::st_comp: begin
            arr_en = 1'b1;
            arr_cmp = 1'b1;
            arr_write = req_wr && arr_hit;
         end
         cache_pkg::st_wb: begin
            // Read out the victim word being written back
            arr_en = 1'b1;
            arr_word_sel = cnt[1:0];
         end
         cache_pkg::st_fill: begin
            // Install each word as its bank returns it
            arr_en = mem_rvalid;
            arr_write = mem_rvalid;
            arr_valid_in = 1'b1;
            arr_word_sel = mem_rword;
            arr_wdata = mem_rdata;
         end
         cache_pkg::st_done: begin
            // Merge of write data on a write miss
            arr_en = req_wr;
            arr_cmp = 1'b1;
            arr_write = req_wr;
         end
         default: ;
      endcase
   end

   // Memory request address with the victim tag during write-back
   always_comb begin
      mem_a = req_a;
      mem_a.cache.byte_sel = 1'b0;
      mem_a.cache.word_sel = cnt[1:0];
      if (state == cache_pkg::st_wb) begin
         mem_a.cache.tag = arr_tag_out;
      end
   end

   assign mem_addr = mem_a;
   assign mem_wdata = arr_rdata;
   assign mem_wr = (state == cache_pkg::st_wb);
   assign mem_rd = (state == cache_pkg::st_fill) && !cnt[2];

   // Processor side
   assign stall = (state != cache_pkg::st_idle);
   assign err = (state == cache_pkg::st_err);
   assign cache_hit = (state == cache_pkg::st_comp) && arr_hit;
   assign done = cache_hit || (state == cache_pkg::st_done);
   assign rdata = (state == cache_pkg::st_comp) ? arr_rdata : rdata_q;

   // Processor honours stall
   a_no_strobe_in_stall : assert property (
      @(posedge clk) disable iff (rst) stall |-> !(rd || wr)
   );

   // Held-off request stays up with the same address
   a_hold_on_busy : assert property (
      @(posedge clk) disable iff (rst)
      ((mem_rd || mem_wr) && mem_busy) |=> ((mem_rd || mem_wr) && $stable(mem_addr))
   );

endmodule

//--- bank_dispatch.sv
// Memory request dispatcher
`timescale 1ns/10ps

module bank_dispatch (
   input  logic clk,
   input  logic rst,
   input  logic mem_rd,
   input  logic mem_wr,
   input  logic [cache_pkg::word_w-1:0] mem_addr,
   input  logic [cache_pkg::word_w-1:0] mem_wdata,
   output logic mem_busy,
   output logic [cache_pkg::num_banks-1:0] bank_req,
   output logic [cache_pkg::num_banks-1:0] bank_we,
   output logic [cache_pkg::num_banks-1:0][cache_pkg::row_w-1:0] bank_row,
   output logic [cache_pkg::num_banks-1:0][cache_pkg::word_w-1:0] bank_wdata,
   input  logic [cache_pkg::num_banks-1:0] bank_busy
);

   cache_pkg::addr_u a;
   // One-hot bank select
   logic [cache_pkg::num_banks-1:0] sel;

   assign a = mem_addr;

   always_comb begin
      sel = '0;
      sel[a.bank.bank] = 1'b1;
   end

   // Request reaches only the addressed bank, and only when it is free
   assign bank_req = {cache_pkg::num_banks{mem_rd || mem_wr}} & sel & ~bank_busy;
   assign bank_we = {cache_pkg::num_banks{mem_wr}} & sel;

   // Row and data fan out to every bank
   always_comb begin
      for (int i = 0; i < cache_pkg::num_banks; i++) begin
         bank_row[i] = a.bank.row;
         bank_wdata[i] = mem_wdata;
      end
   end

   assign mem_busy = bank_busy[a.bank.bank];

   // Controller never reads and writes in one cycle
   a_rd_wr_excl : assert property (
      @(posedge clk) disable iff (rst) !(mem_rd && mem_wr)
   );

endmodule

//--- mem_bank.sv
// Single memory bank
`timescale 1ns/10ps

module mem_bank (
   input  logic clk,
   input  logic rst,
   input  logic req,
   input  logic we,
   input  logic [cache_pkg::row_w-1:0] row,
   input  logic [cache_pkg::word_w-1:0] wdata,
   output logic busy,
   output logic rvalid,
   output logic [cache_pkg::word_w-1:0] rdata
);

   logic [cache_pkg::word_w-1:0] mem [2**cache_pkg::row_w];
   // First read stage
   logic rd_v1;
   logic [cache_pkg::word_w-1:0] rd_d1;
   // One bit per busy cycle left
   logic [cache_pkg::bank_lat-1:0] busy_sr;

   // Storage and read data pipe
   always_ff @(posedge clk) begin
      if (req && we) begin
         mem[row] <= wdata;
      end
      rd_d1 <= mem[row];
      rdata <= rd_d1;
   end

   // Read valid pipe and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_v1 <= 1'b0;
         rvalid <= 1'b0;
         busy_sr <= '0;
      end else begin
         rd_v1 <= req && !we;
         rvalid <= rd_v1;
         if (req) begin
            busy_sr <= '1;
         end else begin
            busy_sr <= busy_sr >> 1;
         end
      end
   end

   assign busy = |busy_sr;

   // Dispatcher holds off requests to an occupied bank
   a_no_req_busy : assert property (
      @(posedge clk) disable iff (rst) req |-> !busy
   );

endmodule

//--- bank_collect.sv
// Bank read return merge
`timescale 1ns/10ps

module bank_collect (
   input  logic [cache_pkg::num_banks-1:0] bank_rvalid,
   input  logic [cache_pkg::num_banks-1:0][cache_pkg::word_w-1:0] bank_rdata,
   output logic mem_rvalid,
   output logic [cache_pkg::word_w-1:0] mem_rdata,
   output logic [cache_pkg::word_sel_w-1:0] mem_rword
);

   // Bank number doubles as word index within the block
   always_comb begin
      mem_rvalid = |bank_rvalid;
      mem_rdata = '0;
      mem_rword = '0;
      for (int i = 0; i < cache_pkg::num_banks; i++) begin
         if (bank_rvalid[i]) begin
            mem_rdata = bank_rdata[i];
            mem_rword = i[cache_pkg::word_sel_w-1:0];
         end
      end
   end

   // One issue per cycle means one return per cycle
   always_comb begin
      a_one_return : assert ($onehot0(bank_rvalid));
   end

endmodule

//--- mem_system.sv
// Cached banked memory system
`timescale 1ns/10ps

module mem_system (
   input  logic clk,
   input  logic rst,
   input  logic [cache_pkg::word_w-1:0] addr,
   input  logic [cache_pkg::word_w-1:0] wdata,
   input  logic rd,
   input  logic wr,
   output logic [cache_pkg::word_w-1:0] rdata,
   output logic done,
   output logic cache_hit,
   output logic stall,
   output logic err
);

   // Controller to cache array
   logic arr_en;
   logic arr_cmp;
   logic arr_write;
   logic arr_valid_in;
   logic arr_dirty_in;
   logic [cache_pkg::index_w-1:0] arr_index;
   logic [cache_pkg::tag_w-1:0] arr_tag;
   logic [cache_pkg::word_sel_w-1:0] arr_word_sel;
   logic [cache_pkg::word_w-1:0] arr_wdata;
   logic arr_hit;
   logic arr_valid;
   logic arr_dirty;
   logic [cache_pkg::tag_w-1:0] arr_tag_out;
   logic [cache_pkg::word_w-1:0] arr_rdata;

   // Controller to memory
   logic mem_rd;
   logic mem_wr;
   logic [cache_pkg::word_w-1:0] mem_addr;
   logic [cache_pkg::word_w-1:0] mem_wdata;
   logic mem_busy;
   logic mem_rvalid;
   logic [cache_pkg::word_sel_w-1:0] mem_rword;
   logic [cache_pkg::word_w-1:0] mem_rdata;

   // Per-bank links
   logic [cache_pkg::num_banks-1:0] bank_req;
   logic [cache_pkg::num_banks-1:0] bank_we;
   logic [cache_pkg::num_banks-1:0][cache_pkg::row_w-1:0] bank_row;
   logic [cache_pkg::num_banks-1:0][cache_pkg::word_w-1:0] bank_wdata;
   logic [cache_pkg::num_banks-1:0] bank_busy;
   logic [cache_pkg::num_banks-1:0] bank_rvalid;
   logic [cache_pkg::num_banks-1:0][cache_pkg::word_w-1:0] bank_rdata;

   cache_ctrl ctrl_i (
      .clk, .rst, .addr, .wdata, .rd, .wr,
      .rdata, .done, .cache_hit, .stall, .err,
      .arr_en, .arr_cmp, .arr_write, .arr_valid_in, .arr_dirty_in,
      .arr_index, .arr_tag, .arr_word_sel, .arr_wdata,
      .arr_hit, .arr_valid, .arr_dirty, .arr_tag_out, .arr_rdata,
      .mem_rd, .mem_wr, .mem_addr, .mem_wdata,
      .mem_busy, .mem_rvalid, .mem_rword, .mem_rdata
   );

   cache_array array_i (
      .clk, .rst,
      .en(arr_en), .cmp(arr_cmp), .write(arr_write),
      .valid_in(arr_valid_in), .dirty_in(arr_dirty_in),
      .index(arr_index), .tag(arr_tag), .word_sel(arr_word_sel), .wdata(arr_wdata),
      .hit(arr_hit), .valid(arr_valid), .dirty(arr_dirty),
      .tag_out(arr_tag_out), .rdata(arr_rdata)
   );

   bank_dispatch dispatch_i (
      .clk, .rst, .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_busy,
      .bank_req, .bank_we, .bank_row, .bank_wdata, .bank_busy
   );

   // Four interleaved banks
   for (genvar b = 0; b < cache_pkg::num_banks; b++) begin : g_bank
      mem_bank bank_i (
         .clk, .rst,
         .req(bank_req[b]), .we(bank_we[b]), .row(bank_row[b]), .wdata(bank_wdata[b]),
         .busy(bank_busy[b]), .rvalid(bank_rvalid[b]), .rdata(bank_rdata[b])
      );
   end

   bank_collect collect_i (
      .bank_rvalid, .bank_rdata, .mem_rvalid, .mem_rdata, .mem_rword
   );

endmodule

//--- tb_mem_system.sv
// Memory system testbench
`timescale 1ns/10ps

module tb_mem_system;

   // Run limit of about 300 accesses at up to 25 cycles each plus margin
   localparam int max_cycles = 10000;
   // Worst miss is well under this
   localparam int done_limit = 64;
   localparam int tag_lsb = 1 + cache_pkg::word_sel_w;
   localparam int idx_lsb = tag_lsb + cache_pkg::tag_w;

   logic clk;
   logic rst;
   logic [cache_pkg::word_w-1:0] addr;
   logic [cache_pkg::word_w-1:0] wdata;
   logic rd;
   logic wr;
   logic [cache_pkg::word_w-1:0] rdata;
   logic done;
   logic cache_hit;
   logic stall;
   logic err;

   // Reference model of word memory plus per-index tag and valid
   logic [cache_pkg::word_w-1:0] mem_model [2**(cache_pkg::word_w-1)];
   bit known [2**(cache_pkg::word_w-1)];
   logic [cache_pkg::tag_w-1:0] tag_model [cache_pkg::num_lines];
   bit valid_model [cache_pkg::num_lines];

   int seed;
   int errors;
   int tests_run;
   int tests_failed;
   int cycle_cnt;
   logic last_hit;

   mem_system dut_i (
      .clk, .rst, .addr, .wdata, .rd, .wr,
      .rdata, .done, .cache_hit, .stall, .err
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Hang guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Run stopped after %0d cycles without finishing", cycle_cnt);
         $display("Some tests failed");
         $finish;
      end
   end

   function automatic logic [cache_pkg::index_w-1:0] index_of(input logic [15:0] a);
      return a[idx_lsb +: cache_pkg::index_w];
   endfunction

   function automatic logic [cache_pkg::tag_w-1:0] tag_of(input logic [15:0] a);
      return a[tag_lsb +: cache_pkg::tag_w];
   endfunction

   // Whole words only with the byte bit dropped
   function automatic logic [14:0] key_of(input logic [15:0] a);
      return a[15:1];
   endfunction

   function automatic logic [15:0] make_addr(input logic [7:0] idx, input logic [4:0] tg,
                                             input logic [1:0] w);
      return {idx, tg, w, 1'b0};
   endfunction

   task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic clear_model();
      foreach (known[k]) known[k] = 1'b0;
      foreach (valid_model[k]) valid_model[k] = 1'b0;
   endtask

   task automatic apply_reset();
      rst <= 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before) begin
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: FAILED with %0d errors", name, errors - err_before);
      end
   endtask

   // One strobe, wait for done, check against the model
   task automatic access(input bit is_wr, input logic [15:0] a, input logic [15:0] d);
      int waits;
      bit exp_hit;
      logic [14:0] key;
      logic [7:0] idx;
      logic [4:0] tg;
      idx = index_of(a);
      tg = tag_of(a);
      key = key_of(a);
      exp_hit = valid_model[idx] && (tag_model[idx] == tg);
      rd <= !is_wr;
      wr <= is_wr;
      addr <= a;
      wdata <= d;
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      waits = 1;
      while (done !== 1'b1 && waits < done_limit) begin
         @(posedge clk);
         waits++;
      end
      last_hit = cache_hit;
      if (done !== 1'b1) begin
         errors++;
         $display("No done within %0d cycles of the access to %h", done_limit, a);
      end else begin
         check_value("cache_hit", exp_hit, cache_hit);
         check_value("stall", 1'b1, stall);
         // Hit gives done in the cycle right after the strobe
         if (exp_hit && waits != 2) begin
            errors++;
            $display("Hit at %h gave done %0d cycles after the strobe", a, waits - 1);
         end
         if (!is_wr && known[key]) begin
            check_value("rdata", mem_model[key], rdata);
         end
      end
      valid_model[idx] = 1'b1;
      tag_model[idx] = tg;
      if (is_wr) begin
         mem_model[key] = d;
         known[key] = 1'b1;
      end
   endtask

   task automatic reset_state_test();
      int e0;
      e0 = errors;
      check_value("done", 1'b0, done);
      check_value("stall", 1'b0, stall);
      check_value("err", 1'b0, err);
      access(1'b1, make_addr(8'h05, 5'h01, 2'd2), 16'h1234);
      check_value("cache_hit", 1'b0, last_hit);
      report_test("reset_state", e0);
   endtask

   task automatic write_read_test();
      int e0;
      logic [15:0] a;
      e0 = errors;
      a = make_addr(8'h11, 5'h07, 2'd1);
      access(1'b1, a, 16'hbeef);
      access(1'b0, a, 16'h0000);
      check_value("cache_hit", 1'b1, last_hit);
      // Write hit then read back the new word
      access(1'b1, a, 16'h5a5a);
      access(1'b0, a, 16'h0000);
      report_test("write_read", e0);
   endtask

   task automatic block_fill_test();
      int e0;
      logic [31:0] r;
      e0 = errors;
      for (int w = 0; w < 4; w++) begin
         r = $random(seed);
         access(1'b1, make_addr(8'h20, 5'h01, w[1:0]), r[15:0]);
      end
      // Conflicting tag pushes the block out to memory
      access(1'b1, make_addr(8'h20, 5'h02, 2'd0), 16'h0f0f);
      // Write miss brings it back and merges word 1
      access(1'b1, make_addr(8'h20, 5'h01, 2'd1), 16'hc3c3);
      for (int w = 0; w < 4; w++) begin
         access(1'b0, make_addr(8'h20, 5'h01, w[1:0]), 16'h0000);
         check_value("cache_hit", 1'b1, last_hit);
      end
      report_test("block_fill", e0);
   endtask

   task automatic evict_test();
      int e0;
      e0 = errors;
      access(1'b1, make_addr(8'h30, 5'h04, 2'd3), 16'haaaa);
      access(1'b1, make_addr(8'h30, 5'h09, 2'd3), 16'h5555);
      access(1'b0, make_addr(8'h30, 5'h04, 2'd3), 16'h0000);
      check_value("cache_hit", 1'b0, last_hit);
      report_test("evict_writeback", e0);
   endtask

   task automatic random_mix_test();
      int e0;
      logic [31:0] r;
      logic [7:0] idx;
      e0 = errors;
      // Four indexes and four tags, so conflicts are common
      for (int i = 0; i < 200; i++) begin
         r = $random(seed);
         idx = 8'h40 + {6'd0, r[1:0]};
         access(r[6], make_addr(idx, {3'd0, r[3:2]}, r[5:4]), r[31:16]);
      end
      report_test("random_mix", e0);
   endtask

   task automatic error_state_test();
      int e0;
      e0 = errors;
      rd <= 1'b1;
      wr <= 1'b1;
      addr <= make_addr(8'h50, 5'h01, 2'd0);
      wdata <= 16'h7777;
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      @(posedge clk);
      check_value("err", 1'b1, err);
      repeat (20) begin
         @(posedge clk);
         check_value("err", 1'b1, err);
         check_value("stall", 1'b1, stall);
         check_value("done", 1'b0, done);
      end
      apply_reset();
      // Dirty lines are lost with the reset
      clear_model();
      check_value("err", 1'b0, err);
      check_value("stall", 1'b0, stall);
      access(1'b1, make_addr(8'h50, 5'h01, 2'd0), 16'h2468);
      access(1'b0, make_addr(8'h50, 5'h01, 2'd0), 16'h0000);
      report_test("error_state", e0);
   endtask

   initial begin
      rst = 1'b1;
      rd = 1'b0;
      wr = 1'b0;
      addr = '0;
      wdata = '0;
      seed = 32'h4589;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      cycle_cnt = 0;
      clear_model();
      apply_reset();
      reset_state_test();
      write_read_test();
      block_fill_test();
      evict_test();
      random_mix_test();
      error_state_test();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
cache_pkg.sv
cache_array.sv
cache_ctrl.sv
bank_dispatch.sv
mem_bank.sv
bank_collect.sv
mem_system.sv
tb_mem_system.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mem_system
FILELIST = verilog.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
